// File: Bender.yml
# Packet router with a Wishbone-programmed route table and four egress ports
package:
  name: flow_router

dependencies: {}

sources:
  # Package first, then the RTL leaves, then the top level
  - files:
      - hdl/flow_pkg.sv
      - hdl/flow_demux_select_unstable.sv
      - hdl/route_table.sv
      - hdl/flow_skid_buffer.sv
      - hdl/flow_router_top.sv

  # Simulation only
  - target: test
    files:
      - dv/flow_router_tb.sv

// File: compile.f
hdl/flow_pkg.sv
hdl/flow_demux_select_unstable.sv
hdl/route_table.sv
hdl/flow_skid_buffer.sv
hdl/flow_router_top.sv
dv/flow_router_tb.sv

// File: dv/flow_router_tb.sv
// Testbench for the packet router; drives ingress, egress readies and Wishbone and checks routing
`timescale 1ns/1ps

module flow_router_tb;

  // Cycle limits for each kind of wait
  localparam int WaitLimit  = 1000;
  localparam int DrainLimit = 5000;
  localparam int NumWords   = 200;

  logic                                clk;
  logic                                rstN;
  logic                                inValid;
  logic                                inReady;
  flow_pkg::flowWord_t                 inData;
  logic [flow_pkg::NumPorts-1:0]       outValid;
  logic [flow_pkg::NumPorts-1:0]       outReady;
  flow_pkg::flowWord_t                 outData [flow_pkg::NumPorts];
  logic                                wbCyc;
  logic                                wbStb;
  logic                                wbWe;
  logic [flow_pkg::WbAdrWidth-1:0]     wbAdr;
  logic [flow_pkg::WbDataWidth-1:0]    wbDatW;
  logic [flow_pkg::WbDataWidth/8-1:0]  wbSel;
  logic [flow_pkg::WbDataWidth-1:0]    wbDatR;
  logic                                wbAck;

  integer seed = 32'ha3bd2bb5;
  string  testName = "reset";

  // Reference copy of the route table, and the words each port still owes
  flow_pkg::portIdx_t  refTable [flow_pkg::NumDests];
  flow_pkg::flowWord_t expQ [flow_pkg::NumPorts][$];

  // Egress ready control: random readies, and ports held stalled
  logic                          randomReady = 1'b0;
  logic [flow_pkg::NumPorts-1:0] stallMask = '0;

  // Last edge's stall state per port, for the stability check
  logic                          wasStalled [flow_pkg::NumPorts];
  flow_pkg::flowWord_t           heldData [flow_pkg::NumPorts];

  flow_router_top i_flow_router_top (
    .clk(clk), .rstN(rstN),
    .inValid(inValid), .inReady(inReady), .inData(inData),
    .outValid(outValid), .outReady(outReady), .outData(outData),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatW(wbDatW), .wbSel(wbSel), .wbDatR(wbDatR), .wbAck(wbAck)
  );

  always #5 clk = ~clk;

  // ------------------------------
  // Reporting and compares
  // ------------------------------

  task automatic stopRun();
    $display("Testbench failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic reportProblem(input string what);
    $display("%s", what);
    stopRun();
  endtask

  task automatic checkWord(input string name, input flow_pkg::flowWord_t expected,
                           input flow_pkg::flowWord_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      stopRun();
    end
  endtask

  task automatic checkPort(input string name, input flow_pkg::portIdx_t expected,
                           input flow_pkg::portIdx_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
      stopRun();
    end
  endtask

  task automatic checkCount(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
      stopRun();
    end
  endtask

  // The port a word should leave on, taken from the reference table copy
  function automatic flow_pkg::portIdx_t expectedPort(input logic [flow_pkg::DestWidth-1:0] dest);
    return refTable[dest];
  endfunction

  // ------------------------------
  // Drivers
  // ------------------------------

  // One classic access; the request is seen on the first edge, ack is expected on the next
  task automatic wbAccess(input logic write, input logic [31:0] adr, input logic [31:0] datW,
                          output logic [31:0] datR);
    int cycles;
    cycles = 0;
    @(posedge clk);
    wbCyc  <= 1'b1;
    wbStb  <= 1'b1;
    wbWe   <= write;
    wbAdr  <= adr;
    wbDatW <= datW;
    wbSel  <= 4'hF;
    @(posedge clk);
    while (!wbAck) begin
      if (cycles == WaitLimit) reportProblem("Timeout waiting for wbAck on a Wishbone access");
      @(posedge clk);
      cycles++;
    end
    checkCount({testName, " wbAck latency"}, 1, cycles);
    datR = wbDatR;
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe  <= 1'b0;
  endtask

  task automatic wbWrite(input logic [31:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wbAccess(1'b1, adr, data, unused);
  endtask

  task automatic wbRead(input logic [31:0] adr, output flow_pkg::portIdx_t entry);
    logic [31:0] data;
    wbAccess(1'b0, adr, '0, data);
    // Entries are zero-extended on the bus
    if (data[31:2] !== '0) reportProblem("Wishbone read data has nonzero upper bits");
    entry = data[1:0];
  endtask

  // Holds the current word until the edge where inReady is seen high
  task automatic waitAccept(input string what);
    int cycles;
    cycles = 0;
    while (!inReady) begin
      if (cycles == WaitLimit) reportProblem({"Timeout waiting for inReady while ", what});
      @(posedge clk);
      cycles++;
    end
  endtask

  task automatic sendWord(input flow_pkg::flowWord_t w);
    inValid <= 1'b1;
    inData  <= w;
    @(posedge clk);
    waitAccept("sending a word");
  endtask

  // Random words with the odd idle cycle in between
  task automatic sendRandom(input int count);
    int r;
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      if (r[2:0] == 3'd0) begin
        inValid <= 1'b0;
        @(posedge clk);
      end
      sendWord(flow_pkg::flowWord_t'($random(seed)));
    end
    inValid <= 1'b0;
  endtask

  // Waits until every expected word has left and all outputs are idle
  task automatic drainAll();
    int cycles;
    cycles = 0;
    // The last ingress handshake reaches the scoreboard on this edge
    @(posedge clk);
    while ((expQ[0].size() + expQ[1].size() + expQ[2].size() + expQ[3].size() != 0)
           || (outValid != '0)) begin
      if (cycles == DrainLimit) reportProblem({"Timeout: words never left the router in ", testName});
      @(posedge clk);
      cycles++;
    end
  endtask

  // ------------------------------
  // Egress readies
  // ------------------------------

  always @(posedge clk) begin
    int r;
    r = $random(seed);
    outReady <= (randomReady ? r[3:0] : 4'hF) & ~stallMask;
  end

  // ------------------------------
  // Monitor and scoreboards
  // ------------------------------

  // An ack seen at this edge means the write already landed on the previous edge,
  // so the table copy is updated before this edge's ingress word is routed
  always @(posedge clk) begin
    flow_pkg::flowWord_t expWord;
    if (rstN) begin
      if (wbCyc && wbStb && wbAck && wbWe && wbSel[0]) begin
        refTable[wbAdr[5:2]] = wbDatW[1:0];
      end
      if (inValid && inReady) begin
        expQ[expectedPort(inData.dest)].push_back(inData);
      end
      for (int p = 0; p < flow_pkg::NumPorts; p++) begin
        // A stalled port must still show the same word
        if (wasStalled[p]) begin
          if (!outValid[p]) reportProblem($sformatf("Port %0d dropped outValid while stalled", p));
          checkWord($sformatf("%s, stable data port %0d", testName, p), heldData[p], outData[p]);
        end
        if (outValid[p] && outReady[p]) begin
          if (expQ[p].size() == 0) reportProblem($sformatf("Port %0d sent an unexpected word", p));
          expWord = expQ[p].pop_front();
          checkWord($sformatf("%s, port %0d", testName, p), expWord, outData[p]);
        end
        wasStalled[p] = outValid[p] && !outReady[p];
        heldData[p]   = outData[p];
      end
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    flow_pkg::portIdx_t entry;
    flow_pkg::portIdx_t written [flow_pkg::NumDests];
    flow_pkg::portIdx_t oldPort;
    flow_pkg::portIdx_t newPort;
    int r;
    int accepted;
    logic stalled;

    clk = 1'b0;
    rstN = 1'b0;
    inValid = 1'b0;
    inData = '0;
    outReady = '0;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = '0;
    wbDatW = '0;
    wbSel = '0;
    for (int d = 0; d < flow_pkg::NumDests; d++) refTable[d] = flow_pkg::portIdx_t'(d % 4);
    for (int p = 0; p < flow_pkg::NumPorts; p++) wasStalled[p] = 1'b0;

    repeat (8) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);

    // Reset state and the round-robin table
    if (outValid != '0) reportProblem("An outValid is high after reset");
    if (!inReady) reportProblem("inReady is low after reset");
    if (wbAck) reportProblem("wbAck is high after reset");
    for (int d = 0; d < flow_pkg::NumDests; d++) begin
      wbRead(d << 2, entry);
      checkPort($sformatf("%s, entry %0d", testName, d), flow_pkg::portIdx_t'(d % 4), entry);
    end

    // Random entries, with junk in the ignored upper address bits
    testName = "table programming";
    for (int d = 0; d < flow_pkg::NumDests; d++) begin
      r = $random(seed);
      written[d] = r[1:0];
      wbWrite({r[31:6], 4'(d), 2'b00}, {30'd0, written[d]});
    end
    for (int d = 0; d < flow_pkg::NumDests; d++) begin
      wbRead(d << 2, entry);
      checkPort($sformatf("%s, entry %0d", testName, d), written[d], entry);
    end

    testName = "routing";
    sendRandom(NumWords);
    drainAll();

    testName = "back-pressure";
    randomReady <= 1'b1;
    sendRandom(NumWords);
    drainAll();
    randomReady <= 1'b0;

    // Fill one port, then move its dest elsewhere while the ingress word is held
    testName = "rewrite under stall";
    oldPort = refTable[9];
    newPort = oldPort + 1'b1;
    stallMask <= 4'b0001 << oldPort;
    repeat (2) @(posedge clk);
    accepted = 0;
    stalled = 1'b0;
    while (!stalled) begin
      if (accepted == WaitLimit) reportProblem("The stalled port never dropped inReady");
      inValid <= 1'b1;
      inData  <= {4'd9, 28'($random(seed))};
      @(posedge clk);
      if (inReady) accepted++;
      else stalled = 1'b1;
    end
    wbWrite(9 << 2, {30'd0, newPort});
    waitAccept("the held word waits for the rewritten route");
    for (int i = 0; i < 3; i++) sendWord({4'd9, 28'($random(seed))});
    inValid <= 1'b0;
    repeat (10) @(posedge clk);
    stallMask <= '0;
    drainAll();

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: hdl/flow_demux_select_unstable.sv
// Combinational ready-valid demux steered by a binary select, used to fan ingress words out
`timescale 1ns/1ps

module flow_demux_select_unstable #(
  // Needs at least two flows to be a demux at all
  parameter int  NumFlows  = 2,
  parameter type payload_t = logic
) (
  // The clock and reset only feed the checks below
  input  logic                 clk,
  input  logic                 rstN,

  // The select may move while the chosen flow is stalled, so the pop side is unstable
  input  flow_pkg::portIdx_t   select,

  output logic                 pushReady,
  input  logic                 pushValid,
  input  payload_t             pushData,

  input  logic [NumFlows-1:0]  popReady,
  output logic [NumFlows-1:0]  popValidUnstable,
  output payload_t             popDataUnstable [NumFlows]
);

  // ------------------------------
  // Integration checks
  // ------------------------------

  // A valid word must name one of the flows that exist
  selectInRangeA : assert property (@(posedge clk) disable iff (!rstN)
    pushValid |-> (int'(select) < NumFlows));

  // The push source has to hold its word until the selected flow takes it
  pushValidStableA : assert property (@(posedge clk) disable iff (!rstN)
    pushValid && !pushReady |=> pushValid);

  // ------------------------------
  // Steering
  // ------------------------------

  // Ready comes back from whichever flow is selected right now
  assign pushReady = popReady[select];

  // Only the selected flow sees valid, and none does while push is idle
  always_comb begin
    for (int i = 0; i < NumFlows; i++) begin
      popValidUnstable[i] = pushValid && (int'(select) == i);
    end
  end

  // Data goes to every flow; only the one with valid high will sample it
  always_comb begin
    for (int i = 0; i < NumFlows; i++) begin
      popDataUnstable[i] = pushData;
    end
  end

  // ------------------------------
  // Implementation checks
  // ------------------------------

  // With push held under back-pressure, a pop valid can only drop because select moved
  for (genvar i = 0; i < NumFlows; i++) begin : genPopChecks
    popValidDropBySelectA : assert property (@(posedge clk) disable iff (!rstN)
      $fell(popValidUnstable[i]) && !popReady[i] && $past(!popReady[i])
        |-> $changed(select));
  end

endmodule

// File: hdl/flow_pkg.sv
// Shared sizes and types of the packet router, referenced by scoped names from every RTL file
package flow_pkg;

  // ------------------------------
  // Router sizes
  // ------------------------------

  // Number of egress ports behind the demux
  localparam int NumPorts = 4;

  // Width of an egress port index, enough to name every port
  localparam int PortIdxWidth = 2;

  // Width of the destination field carried in the upper bits of a word
  localparam int DestWidth = 4;

  // One route table entry exists per destination value
  localparam int NumDests = 16;

  // Payload bits below the destination field
  localparam int PayloadWidth = 28;

  // ------------------------------
  // Wishbone sizes
  // ------------------------------

  // Byte address width of the table's Wishbone slave port
  localparam int WbAdrWidth = 32;

  // Read and write data are single 32-bit words
  localparam int WbDataWidth = 32;

  // ------------------------------
  // Types
  // ------------------------------

  // Egress port number, used both for table entries and for the demux select
  typedef logic [PortIdxWidth-1:0] portIdx_t;

  // One flow word, with the destination in the top nibble
  typedef struct packed {
    logic [DestWidth-1:0]    dest;
    logic [PayloadWidth-1:0] payload;
  } flowWord_t;

endpackage

// File: hdl/flow_router_top.sv
// Top level of the packet router; ties the route table, the demux and the egress buffers together
`timescale 1ns/1ps

module flow_router_top (
  input  logic                                clk,
  input  logic                                rstN,

  // ------------------------------
  // Ingress
  // ------------------------------
  input  logic                                inValid,
  output logic                                inReady,
  input  flow_pkg::flowWord_t                 inData,

  // ------------------------------
  // Egress, one entry per port
  // ------------------------------
  output logic [flow_pkg::NumPorts-1:0]       outValid,
  input  logic [flow_pkg::NumPorts-1:0]       outReady,
  output flow_pkg::flowWord_t                 outData [flow_pkg::NumPorts],

  // ------------------------------
  // Wishbone slave to the table
  // ------------------------------
  input  logic                                wbCyc,
  input  logic                                wbStb,
  input  logic                                wbWe,
  input  logic [flow_pkg::WbAdrWidth-1:0]     wbAdr,
  input  logic [flow_pkg::WbDataWidth-1:0]    wbDatW,
  input  logic [flow_pkg::WbDataWidth/8-1:0]  wbSel,
  output logic [flow_pkg::WbDataWidth-1:0]    wbDatR,
  output logic                                wbAck
);

  // Port chosen by the table for the word at the ingress right now
  flow_pkg::portIdx_t                   routeSel;

  // Demux outputs, which may change under a stall when the table is rewritten
  logic [flow_pkg::NumPorts-1:0]        demuxValid;
  flow_pkg::flowWord_t                  demuxData [flow_pkg::NumPorts];

  // Push-side readies of the egress buffers
  logic [flow_pkg::NumPorts-1:0]        bufReady;

  // The table looks up the dest of the current ingress word with no delay
  route_table i_route_table (
    .clk        (clk),
    .rstN       (rstN),
    .wbCyc      (wbCyc),
    .wbStb      (wbStb),
    .wbWe       (wbWe),
    .wbAdr      (wbAdr),
    .wbDatW     (wbDatW),
    .wbSel      (wbSel),
    .wbDatR     (wbDatR),
    .wbAck      (wbAck),
    .lookupDest (inData.dest),
    .routeSel   (routeSel)
  );

  // Ingress stalls only while the selected port's buffer is full
  flow_demux_select_unstable #(
    .NumFlows  (flow_pkg::NumPorts),
    .payload_t (flow_pkg::flowWord_t)
  ) i_flow_demux_select_unstable (
    .clk              (clk),
    .rstN             (rstN),
    .select           (routeSel),
    .pushReady        (inReady),
    .pushValid        (inValid),
    .pushData         (inData),
    .popReady         (bufReady),
    .popValidUnstable (demuxValid),
    .popDataUnstable  (demuxData)
  );

  // Each port gets its own buffer so that the egress pins follow the stability rule
  for (genvar p = 0; p < flow_pkg::NumPorts; p++) begin : genEgress
    flow_skid_buffer #(
      .payload_t (flow_pkg::flowWord_t)
    ) i_flow_skid_buffer (
      .clk       (clk),
      .rstN      (rstN),
      .pushValid (demuxValid[p]),
      .pushReady (bufReady[p]),
      .pushData  (demuxData[p]),
      .popValid  (outValid[p]),
      .popReady  (outReady[p]),
      .popData   (outData[p])
    );
  end

endmodule

// File: hdl/flow_skid_buffer.sv
// Two-entry registered ready-valid buffer that turns an unstable push stream into a stable pop stream
`timescale 1ns/1ps

module flow_skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rstN,

  input  logic     pushValid,
  output logic     pushReady,
  input  payload_t pushData,

  output logic     popValid,
  input  logic     popReady,
  output payload_t popData
);

  // ------------------------------
  // State
  // ------------------------------

  // The head slot drives the pop side directly
  logic     headValid;
  payload_t headData;

  // The spare slot catches a word that arrives while the head is stalled
  logic     spareValid;
  payload_t spareData;

  // Handshakes on each side in the current cycle
  logic     pushFire;
  logic     popFire;

  // The buffer is only full when the spare slot is taken, so ready is a flop output
  assign pushReady = !spareValid;

  assign pushFire = pushValid && pushReady;
  assign popFire  = headValid && popReady;

  // ------------------------------
  // Occupancy
  // ------------------------------

  // A push cannot coincide with a full buffer, so the spare drains into the head alone
  always_ff @(posedge clk) begin
    if (!rstN) begin
      headValid  <= 1'b0;
      spareValid <= 1'b0;
    end else if (popFire && spareValid) begin
      spareValid <= 1'b0;
    end else if (popFire) begin
      // The head refills from the push side in the same cycle it empties
      headValid <= pushFire;
    end else if (pushFire) begin
      if (headValid) begin
        spareValid <= 1'b1;
      end else begin
        headValid <= 1'b1;
      end
    end
  end

  // ------------------------------
  // Data slots
  // ------------------------------

  // The head only changes when it is empty or being popped, which keeps popData stable
  always_ff @(posedge clk) begin
    if (popFire && spareValid) begin
      headData <= spareData;
    end else if (pushFire && (!headValid || popFire)) begin
      headData <= pushData;
    end
  end

  // The spare loads only when the head is busy and stays put
  always_ff @(posedge clk) begin
    if (pushFire && headValid && !popFire) begin
      spareData <= pushData;
    end
  end

  // Pop side comes straight from the head registers
  assign popValid = headValid;
  assign popData  = headData;

  // ------------------------------
  // Checks
  // ------------------------------

  // Whatever the push side does, a stalled output keeps its word until it is taken
  popStableA : assert property (@(posedge clk) disable iff (!rstN)
    popValid && !popReady |=> popValid && $stable(popData));

endmodule

// File: hdl/route_table.sv
// Destination-to-port route table with a Wishbone classic slave port and a combinational lookup
`timescale 1ns/1ps

module route_table (
  input  logic                                 clk,
  input  logic                                 rstN,

  // Wishbone classic slave, single word accesses only
  input  logic                                 wbCyc,
  input  logic                                 wbStb,
  input  logic                                 wbWe,
  input  logic [flow_pkg::WbAdrWidth-1:0]      wbAdr,
  input  logic [flow_pkg::WbDataWidth-1:0]     wbDatW,
  input  logic [flow_pkg::WbDataWidth/8-1:0]   wbSel,
  output logic [flow_pkg::WbDataWidth-1:0]     wbDatR,
  output logic                                 wbAck,

  // Lookup side, driven by the dest field of the current ingress word
  input  logic [flow_pkg::DestWidth-1:0]       lookupDest,
  output flow_pkg::portIdx_t                   routeSel
);

  // ------------------------------
  // Storage and decode
  // ------------------------------

  // One port index per destination
  flow_pkg::portIdx_t tableQ [flow_pkg::NumDests];

  // Word address bits pick the entry, anything above them is ignored
  logic [flow_pkg::DestWidth-1:0] wbIdx;

  // A new request is one that is present and not yet acknowledged
  logic wbReq;

  assign wbIdx = wbAdr[flow_pkg::DestWidth+1:2];
  assign wbReq = wbCyc && wbStb && !wbAck;

  // ------------------------------
  // Wishbone handshake
  // ------------------------------

  // Ack is raised for exactly one cycle after the request is first seen.
  // Because the ack itself blocks wbReq, a master that keeps wbStb up
  // for the ack cycle does not start a second access
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbAck <= 1'b0;
    end else begin
      wbAck <= wbReq;
    end
  end

  // ------------------------------
  // Table update
  // ------------------------------

  // Reset spreads the destinations round-robin over the ports.
  // A write lands on the same edge that raises wbAck, and only byte lane 0
  // matters because an entry is just two bits wide
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int d = 0; d < flow_pkg::NumDests; d++) begin
        tableQ[d] <= flow_pkg::portIdx_t'(d % flow_pkg::NumPorts);
      end
    end else if (wbReq && wbWe && wbSel[0]) begin
      tableQ[wbIdx] <= wbDatW[flow_pkg::PortIdxWidth-1:0];
    end
  end

  // ------------------------------
  // Read data
  // ------------------------------

  // Read data is captured with the request so that it is valid alongside wbAck.
  // The entry is zero-extended to the full bus width
  always_ff @(posedge clk) begin
    if (wbReq && !wbWe) begin
      wbDatR <= {{(flow_pkg::WbDataWidth - flow_pkg::PortIdxWidth){1'b0}}, tableQ[wbIdx]};
    end
  end

  // ------------------------------
  // Lookup
  // ------------------------------

  // Zero-cycle lookup; the route is whatever the table holds at the accepting edge
  assign routeSel = tableQ[lookupDest];

  // ------------------------------
  // Checks
  // ------------------------------

  // A strobe dropped right after the ack keeps each request to a single access
  wbStbDropA : assert property (@(posedge clk) disable iff (!rstN)
    wbAck |=> !wbStb);

endmodule
